//--- Bender.yml
package:
  name: race_collision

sources:
  - common/map_pkg.sv
  - common/motion_pkg.sv
  - collision/horizontal_track_collision.sv
  - collision/vertical_track_collision.sv
  - collision/circle_track_collision.sv
  - collision/segment_collision.sv
  - verilog/track_table.sv
  - verilog/car_motion.sv
  - verilog/race_collision_top.sv
  - target: simulation
    files:
      - dv/tb_clock.sv
      - dv/race_tb.sv

//--- collision/circle_track_collision.sv
`timescale 1ns/1ps

module circle_track_collision (
    input  map_pkg::circle_track_t                       i_track,
    input  logic signed [map_pkg::MAP_H_WIDTH-1:0]       i_x,
    input  logic signed [map_pkg::MAP_V_WIDTH-1:0]       i_y,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_v_x,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_v_y,
    output logic                                         o_collision
);
    import map_pkg::*;
    import motion_pkg::*;

    localparam int SQ_WIDTH = 2 * MAP_H_WIDTH + 3;
    localparam int DOT_WIDTH = VELOCITY_WIDTH + MAP_H_WIDTH + 2;
    localparam logic signed [MAP_H_WIDTH:0] HALF_SPRITE = (MAP_H_WIDTH + 1)'(IMAGE_SIZE / 2);

    logic                          in_box;
    logic signed [MAP_H_WIDTH:0]   disp_x;
    logic signed [MAP_V_WIDTH:0]   disp_y;
    logic signed [SQ_WIDTH-1:0]    disp_sq;
    logic signed [MAP_H_WIDTH:0]   bound_inner;
    logic signed [MAP_H_WIDTH:0]   bound_outer;
    logic signed [SQ_WIDTH-1:0]    bound_inner_sq;
    logic signed [SQ_WIDTH-1:0]    bound_outer_sq;
    logic signed [DOT_WIDTH-1:0]   radial_dot;

    assign in_box = (i_x >= i_track.x_left) &&
                    (i_x <= i_track.x_right) &&
                    (i_y >= i_track.y_bottom) &&
                    (i_y <= i_track.y_top);

    assign disp_x = i_x - i_track.center_x;
    assign disp_y = i_y - i_track.center_y;
    assign disp_sq = disp_x * disp_x + disp_y * disp_y;

    // sprite centre must stay half a sprite off each wall
    assign bound_inner = i_track.radius_inner + HALF_SPRITE;
    assign bound_outer = i_track.radius_outer - HALF_SPRITE;
    assign bound_inner_sq = bound_inner * bound_inner;
    assign bound_outer_sq = bound_outer * bound_outer;

    // positive means moving away from the centre
    assign radial_dot = i_v_x * disp_x + i_v_y * disp_y;

    always_comb begin
        o_collision = 1'b0;
        if (in_box) begin
            if (disp_sq <= bound_inner_sq && radial_dot < 0) begin
                o_collision = 1'b1;
            end
            if (disp_sq >= bound_outer_sq && radial_dot > 0) begin
                o_collision = 1'b1;
            end
        end
    end

endmodule

//--- collision/horizontal_track_collision.sv
`timescale 1ns/1ps

module horizontal_track_collision (
    input  map_pkg::horizontal_track_t                   i_track,
    input  logic signed [map_pkg::MAP_H_WIDTH-1:0]       i_x,
    input  logic signed [map_pkg::MAP_V_WIDTH-1:0]       i_y,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_v_y,
    output logic                                         o_collision
);
    import map_pkg::*;

    localparam logic signed [MAP_V_WIDTH+1:0] HALF_SPRITE = (MAP_V_WIDTH + 2)'(IMAGE_SIZE / 2);

    logic                          in_box;
    logic signed [MAP_V_WIDTH+1:0] gap_top;
    logic signed [MAP_V_WIDTH+1:0] gap_bottom;

    assign in_box = (i_x >= i_track.x_left) &&
                    (i_x <= i_track.x_right) &&
                    (i_y >= i_track.y_bottom_border) &&
                    (i_y <= i_track.y_top_border);

    // room left between sprite edge and each border
    assign gap_top = i_track.y_top_border - i_y - HALF_SPRITE;
    assign gap_bottom = i_y - HALF_SPRITE - i_track.y_bottom_border;

    always_comb begin
        o_collision = 1'b0;
        if (in_box) begin
            if (gap_top <= 0 && i_v_y > 0) begin
                o_collision = 1'b1;
            end
            if (gap_bottom <= 0 && i_v_y < 0) begin
                o_collision = 1'b1;
            end
        end
    end

endmodule

//--- collision/segment_collision.sv
`timescale 1ns/1ps

module segment_collision (
    input  map_pkg::segment_t                            i_seg,
    input  logic signed [map_pkg::MAP_H_WIDTH-1:0]       i_x,
    input  logic signed [map_pkg::MAP_V_WIDTH-1:0]       i_y,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_v_x,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_v_y,
    output logic                                         o_flip_x,
    output logic                                         o_flip_y
);
    import map_pkg::*;

    logic hit_horizontal;
    logic hit_vertical;
    logic hit_circle;

    // all three views of the same body word, kind picks one below
    horizontal_track_collision u_horizontal (
        .i_track     (i_seg.body.horizontal),
        .i_x         (i_x),
        .i_y         (i_y),
        .i_v_y       (i_v_y),
        .o_collision (hit_horizontal)
    );

    vertical_track_collision u_vertical (
        .i_track     (i_seg.body.vertical),
        .i_x         (i_x),
        .i_y         (i_y),
        .i_v_x       (i_v_x),
        .o_collision (hit_vertical)
    );

    circle_track_collision u_circle (
        .i_track     (i_seg.body.circle),
        .i_x         (i_x),
        .i_y         (i_y),
        .i_v_x       (i_v_x),
        .i_v_y       (i_v_y),
        .o_collision (hit_circle)
    );

    always_comb begin
        o_flip_x = 1'b0;
        o_flip_y = 1'b0;
        case (i_seg.kind)
            SEG_HORIZONTAL: o_flip_y = hit_horizontal;
            SEG_VERTICAL:   o_flip_x = hit_vertical;
            SEG_CIRCLE: begin
                o_flip_x = hit_circle;
                o_flip_y = hit_circle;
            end
            default: ;
        endcase
    end

endmodule

//--- collision/vertical_track_collision.sv
`timescale 1ns/1ps

module vertical_track_collision (
    input  map_pkg::vertical_track_t                     i_track,
    input  logic signed [map_pkg::MAP_H_WIDTH-1:0]       i_x,
    input  logic signed [map_pkg::MAP_V_WIDTH-1:0]       i_y,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_v_x,
    output logic                                         o_collision
);
    import map_pkg::*;

    localparam logic signed [MAP_H_WIDTH+1:0] HALF_SPRITE = (MAP_H_WIDTH + 2)'(IMAGE_SIZE / 2);

    logic                          in_box;
    logic signed [MAP_H_WIDTH+1:0] gap_left;
    logic signed [MAP_H_WIDTH+1:0] gap_right;

    assign in_box = (i_x >= i_track.x_left_border) &&
                    (i_x <= i_track.x_right_border) &&
                    (i_y >= i_track.y_bottom) &&
                    (i_y <= i_track.y_top);

    // negative or zero means the sprite touches the border
    assign gap_left = i_x - HALF_SPRITE - i_track.x_left_border;
    assign gap_right = i_track.x_right_border - i_x - HALF_SPRITE;

    always_comb begin
        o_collision = 1'b0;
        if (in_box) begin
            if (gap_left <= 0 && i_v_x < 0) begin
                o_collision = 1'b1;
            end
            if (gap_right <= 0 && i_v_x > 0) begin
                o_collision = 1'b1;
            end
        end
    end

endmodule

//--- common/map_pkg.sv
package map_pkg;

    // signed screen coordinates, y grows upward
    localparam int MAP_H_WIDTH = 11;
    localparam int MAP_V_WIDTH = 10;

    // sprite edge in pixels
    localparam int IMAGE_SIZE = 16;

    // circle is the widest view, straights pad up to it
    localparam int SEG_BODY_WIDTH = 5 * MAP_H_WIDTH + 3 * MAP_V_WIDTH;
    localparam int STRAIGHT_PAD_WIDTH = SEG_BODY_WIDTH - 2 * MAP_H_WIDTH - 2 * MAP_V_WIDTH;

    typedef enum logic [1:0] {
        SEG_NONE       = 2'd0,
        SEG_HORIZONTAL = 2'd1,
        SEG_VERTICAL   = 2'd2,
        SEG_CIRCLE     = 2'd3
    } seg_kind_t;

    typedef struct packed {
        logic signed [MAP_H_WIDTH-1:0] x_left;
        logic signed [MAP_H_WIDTH-1:0] x_right;
        logic signed [MAP_V_WIDTH-1:0] y_top_border;
        logic signed [MAP_V_WIDTH-1:0] y_bottom_border;
        logic [STRAIGHT_PAD_WIDTH-1:0] padding;
    } horizontal_track_t;

    typedef struct packed {
        logic signed [MAP_H_WIDTH-1:0] x_left_border;
        logic signed [MAP_H_WIDTH-1:0] x_right_border;
        logic signed [MAP_V_WIDTH-1:0] y_top;
        logic signed [MAP_V_WIDTH-1:0] y_bottom;
        logic [STRAIGHT_PAD_WIDTH-1:0] padding;
    } vertical_track_t;

    typedef struct packed {
        logic signed [MAP_H_WIDTH-1:0] x_left;
        logic signed [MAP_H_WIDTH-1:0] x_right;
        logic signed [MAP_V_WIDTH-1:0] y_top;
        logic signed [MAP_V_WIDTH-1:0] y_bottom;
        logic signed [MAP_H_WIDTH-1:0] center_x;
        logic signed [MAP_V_WIDTH-1:0] center_y;
        logic signed [MAP_H_WIDTH-1:0] radius_inner;
        logic signed [MAP_H_WIDTH-1:0] radius_outer;
    } circle_track_t;

    // one body word, read under the view its kind selects
    typedef union packed {
        horizontal_track_t horizontal;
        vertical_track_t   vertical;
        circle_track_t     circle;
    } segment_body_u;

    typedef struct packed {
        seg_kind_t     kind;
        segment_body_u body;
    } segment_t;

endpackage

//--- common/motion_pkg.sv
package motion_pkg;

    // velocity is signed fixed point, integer part above the fraction
    localparam int VELOCITY_INTEGER_WIDTH = 4;
    localparam int VELOCITY_FRACTION_WIDTH = 4;
    localparam int VELOCITY_WIDTH = VELOCITY_INTEGER_WIDTH + VELOCITY_FRACTION_WIDTH;

    // sub-pixel bits kept below the integer position
    localparam int POS_FRACTION_WIDTH = VELOCITY_FRACTION_WIDTH;

endpackage

//--- dv/race_tb.sv
`timescale 1ns/1ps

module race_tb;
    import map_pkg::*;
    import motion_pkg::*;

    localparam int NUM_SEGMENTS = 8;
    localparam int SEG_ADDR_WIDTH = $clog2(NUM_SEGMENTS);
    localparam int FREE_STEPS = 20;
    localparam int DIRECTED_STEPS = 12;
    localparam int RANDOM_STEPS = 200;
    localparam int NUM_STEPS = FREE_STEPS + DIRECTED_STEPS + RANDOM_STEPS;
    localparam int NUM_WRITES = 3 + (RANDOM_STEPS / 25) * NUM_SEGMENTS;
    localparam int NUM_LOADS = FREE_STEPS + DIRECTED_STEPS + RANDOM_STEPS / 5;
    localparam int CYCLE_LIMIT = NUM_STEPS * (NUM_SEGMENTS + 3) +
                                 2 * (NUM_WRITES + NUM_LOADS) + 100;

    logic clk;
    logic i_reset;
    logic i_seg_we;
    logic [SEG_ADDR_WIDTH-1:0] i_seg_addr;
    segment_t i_seg_data;
    logic i_load;
    logic signed [MAP_H_WIDTH-1:0] i_x0;
    logic signed [MAP_V_WIDTH-1:0] i_y0;
    logic signed [VELOCITY_WIDTH-1:0] i_vx0;
    logic signed [VELOCITY_WIDTH-1:0] i_vy0;
    logic i_step;
    logic signed [MAP_H_WIDTH-1:0] o_x;
    logic signed [MAP_V_WIDTH-1:0] o_y;
    logic signed [VELOCITY_WIDTH-1:0] o_v_x;
    logic signed [VELOCITY_WIDTH-1:0] o_v_y;
    logic o_busy;
    logic o_done;
    logic o_hit_x;
    logic o_hit_y;

    // reference state
    segment_t model_mem [NUM_SEGMENTS];
    logic signed [MAP_H_WIDTH+POS_FRACTION_WIDTH-1:0] model_px;
    logic signed [MAP_V_WIDTH+POS_FRACTION_WIDTH-1:0] model_py;
    logic signed [VELOCITY_WIDTH-1:0] model_vx;
    logic signed [VELOCITY_WIDTH-1:0] model_vy;
    logic model_hx;
    logic model_hy;
    int cycles;

    tb_clock #(.PERIOD(100ns)) u_clock (.o_clk(clk));

    race_collision_top #(
        .NUM_SEGMENTS   (NUM_SEGMENTS),
        .SEG_ADDR_WIDTH (SEG_ADDR_WIDTH)
    ) dut0 (
        .i_clk (clk), .i_reset (i_reset),
        .i_seg_we (i_seg_we), .i_seg_addr (i_seg_addr), .i_seg_data (i_seg_data),
        .i_load (i_load), .i_x0 (i_x0), .i_y0 (i_y0), .i_vx0 (i_vx0), .i_vy0 (i_vy0),
        .i_step (i_step),
        .o_x (o_x), .o_y (o_y), .o_v_x (o_v_x), .o_v_y (o_v_y),
        .o_busy (o_busy), .o_done (o_done), .o_hit_x (o_hit_x), .o_hit_y (o_hit_y)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    // border tests, written straight from the clearance rules
    function automatic bit horizontal_hit(segment_t s, int x, int y, int vy);
        int top = s.body.horizontal.y_top_border;
        int bot = s.body.horizontal.y_bottom_border;
        if (x < s.body.horizontal.x_left || x > s.body.horizontal.x_right) return 0;
        if (y < bot || y > top) return 0;
        return (top - y <= IMAGE_SIZE / 2 && vy > 0) || (y - bot <= IMAGE_SIZE / 2 && vy < 0);
    endfunction

    function automatic bit vertical_hit(segment_t s, int x, int y, int vx);
        int lft = s.body.vertical.x_left_border;
        int rgt = s.body.vertical.x_right_border;
        if (x < lft || x > rgt) return 0;
        if (y < s.body.vertical.y_bottom || y > s.body.vertical.y_top) return 0;
        return (x - lft <= IMAGE_SIZE / 2 && vx < 0) || (rgt - x <= IMAGE_SIZE / 2 && vx > 0);
    endfunction

    function automatic bit curve_hit(segment_t s, int x, int y, int vx, int vy);
        int dx = x - s.body.circle.center_x;
        int dy = y - s.body.circle.center_y;
        int rin = s.body.circle.radius_inner + IMAGE_SIZE / 2;
        int rout = s.body.circle.radius_outer - IMAGE_SIZE / 2;
        int dot = vx * dx + vy * dy;
        if (x < s.body.circle.x_left || x > s.body.circle.x_right) return 0;
        if (y < s.body.circle.y_bottom || y > s.body.circle.y_top) return 0;
        return (dx * dx + dy * dy <= rin * rin && dot < 0) ||
               (dx * dx + dy * dy >= rout * rout && dot > 0);
    endfunction

    task automatic model_step();
        int x = model_px >>> POS_FRACTION_WIDTH;
        int y = model_py >>> POS_FRACTION_WIDTH;
        model_hx = 0;
        model_hy = 0;
        for (int i = 0; i < NUM_SEGMENTS; i++) begin
            case (model_mem[i].kind)
                SEG_HORIZONTAL: model_hy |= horizontal_hit(model_mem[i], x, y, model_vy);
                SEG_VERTICAL: model_hx |= vertical_hit(model_mem[i], x, y, model_vx);
                SEG_CIRCLE: begin
                    model_hx |= curve_hit(model_mem[i], x, y, model_vx, model_vy);
                    model_hy |= curve_hit(model_mem[i], x, y, model_vx, model_vy);
                end
                default: ;
            endcase
        end
        if (model_hx) model_vx = -model_vx;
        if (model_hy) model_vy = -model_vy;
        model_px = model_px + model_vx;
        model_py = model_py + model_vy;
    endtask

    task automatic write_seg(input int addr, input segment_t data);
        @(posedge clk);
        i_seg_we <= 1'b1;
        i_seg_addr <= addr[SEG_ADDR_WIDTH-1:0];
        i_seg_data <= data;
        model_mem[addr] = data;
        @(posedge clk);
        i_seg_we <= 1'b0;
    endtask

    task automatic load_car(input int x, input int y, input int vx, input int vy);
        @(posedge clk);
        i_load <= 1'b1;
        i_x0 <= x[MAP_H_WIDTH-1:0];
        i_y0 <= y[MAP_V_WIDTH-1:0];
        i_vx0 <= vx[VELOCITY_WIDTH-1:0];
        i_vy0 <= vy[VELOCITY_WIDTH-1:0];
        model_px = {x[MAP_H_WIDTH-1:0], {POS_FRACTION_WIDTH{1'b0}}};
        model_py = {y[MAP_V_WIDTH-1:0], {POS_FRACTION_WIDTH{1'b0}}};
        model_vx = vx[VELOCITY_WIDTH-1:0];
        model_vy = vy[VELOCITY_WIDTH-1:0];
        @(posedge clk);
        i_load <= 1'b0;
    endtask

    function automatic segment_t random_segment();
        segment_t s;
        int cx = int'($urandom_range(300)) - 150;
        int cy = int'($urandom_range(300)) - 150;
        int w = int'($urandom_range(250)) + 10;
        int h = int'($urandom_range(250)) + 10;
        s = '0;
        s.kind = seg_kind_t'($urandom_range(3));
        // box fields sit in the same place for every view
        s.body.circle.x_left = MAP_H_WIDTH'(cx - w);
        s.body.circle.x_right = MAP_H_WIDTH'(cx + w);
        s.body.circle.y_top = MAP_V_WIDTH'(cy + h);
        s.body.circle.y_bottom = MAP_V_WIDTH'(cy - h);
        s.body.circle.center_x = MAP_H_WIDTH'(cx);
        s.body.circle.center_y = MAP_V_WIDTH'(cy);
        s.body.circle.radius_inner = MAP_H_WIDTH'($urandom_range(120));
        s.body.circle.radius_outer = MAP_H_WIDTH'($urandom_range(300) + 100);
        return s;
    endfunction

    function automatic segment_t make_box(seg_kind_t kind, int xl, int xr, int yt, int yb);
        segment_t s;
        s = '0;
        s.kind = kind;
        s.body.circle.x_left = MAP_H_WIDTH'(xl);
        s.body.circle.x_right = MAP_H_WIDTH'(xr);
        s.body.circle.y_top = MAP_V_WIDTH'(yt);
        s.body.circle.y_bottom = MAP_V_WIDTH'(yb);
        return s;
    endfunction

    task automatic run_step(input bit inject);
        int edges;
        bit seen;
        @(posedge clk);
        i_step <= 1'b1;
        @(posedge clk);
        i_step <= 1'b0;
        model_step();
        edges = 0;
        seen = 0;
        while (!seen) begin
            // traffic during the scan must be ignored
            if (inject && edges < NUM_SEGMENTS) begin
                i_step <= 1'($urandom);
                i_load <= 1'($urandom);
                i_x0 <= MAP_H_WIDTH'($urandom);
                i_vx0 <= VELOCITY_WIDTH'($urandom);
                i_seg_we <= 1'($urandom);
                i_seg_addr <= SEG_ADDR_WIDTH'($urandom);
                i_seg_data <= random_segment();
            end else begin
                i_step <= 1'b0;
                i_load <= 1'b0;
                i_seg_we <= 1'b0;
            end
            @(negedge clk);
            seen = o_done;
            if (!seen) begin
                check_value("o_busy", o_busy, 1);
                @(posedge clk);
                edges++;
            end
        end
        check_value("done latency", edges, NUM_SEGMENTS + 1);
        check_value("o_busy", o_busy, 0);
        check_value("o_x", o_x, model_px >>> POS_FRACTION_WIDTH);
        check_value("o_y", o_y, model_py >>> POS_FRACTION_WIDTH);
        check_value("o_v_x", o_v_x, model_vx);
        check_value("o_v_y", o_v_y, model_vy);
        check_value("o_hit_x", o_hit_x, model_hx);
        check_value("o_hit_y", o_hit_y, model_hy);
    endtask

    task automatic directed_step(input int x, input int y, input int vx, input int vy,
                                 input bit exp_hx, input bit exp_hy);
        load_car(x, y, vx, vy);
        run_step(0);
        check_value("o_hit_x", o_hit_x, exp_hx);
        check_value("o_hit_y", o_hit_y, exp_hy);
    endtask

    initial begin
        segment_t s;
        void'($urandom(32'he39f_b158));
        cycles = 0;
        i_reset = 1'b1;
        {i_seg_we, i_load, i_step} = '0;
        i_seg_addr = '0;
        i_seg_data = '0;
        {i_x0, i_y0, i_vx0, i_vy0} = '0;
        for (int i = 0; i < NUM_SEGMENTS; i++) model_mem[i] = '0;
        repeat (4) @(posedge clk);
        i_reset <= 1'b0;

        // empty table, free motion
        for (int n = 0; n < FREE_STEPS; n++) begin
            load_car(int'($urandom_range(800)) - 400, int'($urandom_range(400)) - 200,
                     int'($urandom_range(255)) - 128, int'($urandom_range(255)) - 128);
            run_step(n % 2);
            check_value("o_hit_x", o_hit_x, 0);
            check_value("o_hit_y", o_hit_y, 0);
        end

        write_seg(0, make_box(SEG_HORIZONTAL, -100, 100, 50, -50));
        directed_step(0, 45, 5, 16, 0, 1);
        directed_step(0, 45, 5, -16, 0, 0);
        directed_step(0, -45, -5, -16, 0, 1);
        directed_step(0, -45, -5, 16, 0, 0);

        write_seg(0, make_box(SEG_VERTICAL, -50, 50, 100, -100));
        directed_step(45, 0, 16, 3, 1, 0);
        directed_step(45, 0, -16, 3, 0, 0);
        directed_step(-45, 0, -16, -3, 1, 0);
        directed_step(-45, 0, 16, -3, 0, 0);

        s = make_box(SEG_CIRCLE, -200, 200, 200, -200);
        s.body.circle.radius_inner = 50;
        s.body.circle.radius_outer = 150;
        write_seg(0, s);
        directed_step(40, 0, -16, 0, 1, 1);
        directed_step(145, 0, 16, 0, 1, 1);
        directed_step(145, 0, 0, 16, 0, 0);
        directed_step(40, 0, 0, -16, 0, 0);

        // mixed random tables, refreshed now and then
        for (int n = 0; n < RANDOM_STEPS; n++) begin
            if (n % 25 == 0) begin
                for (int i = 0; i < NUM_SEGMENTS; i++) write_seg(i, random_segment());
            end
            if (n % 5 == 0) begin
                load_car(int'($urandom_range(400)) - 200, int'($urandom_range(400)) - 200,
                         int'($urandom_range(255)) - 128, int'($urandom_range(255)) - 128);
            end
            run_step(n % 3 == 0);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 100ns
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

//--- list.f
common/map_pkg.sv
common/motion_pkg.sv
collision/horizontal_track_collision.sv
collision/vertical_track_collision.sv
collision/circle_track_collision.sv
collision/segment_collision.sv
verilog/track_table.sv
verilog/car_motion.sv
verilog/race_collision_top.sv
dv/tb_clock.sv
dv/race_tb.sv

//--- verilog/car_motion.sv
`timescale 1ns/1ps

module car_motion #(
    parameter int NUM_SEGMENTS   = 8,
    parameter int SEG_ADDR_WIDTH = $clog2(NUM_SEGMENTS)
) (
    input  logic                                         i_clk,
    input  logic                                         i_reset,
    input  logic                                         i_load,
    input  logic signed [map_pkg::MAP_H_WIDTH-1:0]       i_x0,
    input  logic signed [map_pkg::MAP_V_WIDTH-1:0]       i_y0,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_vx0,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_vy0,
    input  logic                                         i_step,
    input  logic                                         i_flip_x,
    input  logic                                         i_flip_y,
    output logic [SEG_ADDR_WIDTH-1:0]                    o_scan_addr,
    output logic signed [map_pkg::MAP_H_WIDTH-1:0]       o_x,
    output logic signed [map_pkg::MAP_V_WIDTH-1:0]       o_y,
    output logic signed [motion_pkg::VELOCITY_WIDTH-1:0] o_v_x,
    output logic signed [motion_pkg::VELOCITY_WIDTH-1:0] o_v_y,
    output logic                                         o_busy,
    output logic                                         o_done,
    output logic                                         o_hit_x,
    output logic                                         o_hit_y
);
    import map_pkg::*;
    import motion_pkg::*;

    localparam int POS_X_WIDTH = MAP_H_WIDTH + POS_FRACTION_WIDTH;
    localparam int POS_Y_WIDTH = MAP_V_WIDTH + POS_FRACTION_WIDTH;
    localparam logic [SEG_ADDR_WIDTH-1:0] LAST_ADDR = SEG_ADDR_WIDTH'(NUM_SEGMENTS - 1);

    logic signed [POS_X_WIDTH-1:0]    pos_x;
    logic signed [POS_Y_WIDTH-1:0]    pos_y;
    logic                             applying;
    logic signed [VELOCITY_WIDTH-1:0] next_v_x;
    logic signed [VELOCITY_WIDTH-1:0] next_v_y;

    // reflection is plain negation of the hit component
    assign next_v_x = o_hit_x ? -o_v_x : o_v_x;
    assign next_v_y = o_hit_y ? -o_v_y : o_v_y;

    assign o_x = pos_x[POS_X_WIDTH-1:POS_FRACTION_WIDTH];
    assign o_y = pos_y[POS_Y_WIDTH-1:POS_FRACTION_WIDTH];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pos_x       <= '0;
            pos_y       <= '0;
            o_v_x       <= '0;
            o_v_y       <= '0;
            o_scan_addr <= '0;
            o_busy      <= 1'b0;
            o_done      <= 1'b0;
            o_hit_x     <= 1'b0;
            o_hit_y     <= 1'b0;
            applying    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!o_busy) begin
                if (i_load) begin
                    pos_x <= {i_x0, {POS_FRACTION_WIDTH{1'b0}}};
                    pos_y <= {i_y0, {POS_FRACTION_WIDTH{1'b0}}};
                    o_v_x <= i_vx0;
                    o_v_y <= i_vy0;
                end
                if (i_step) begin
                    o_busy      <= 1'b1;
                    o_scan_addr <= '0;
                    o_hit_x     <= 1'b0;
                    o_hit_y     <= 1'b0;
                end
            end else if (!applying) begin
                // several segments may hit, they fold into one flip
                o_hit_x <= o_hit_x | i_flip_x;
                o_hit_y <= o_hit_y | i_flip_y;
                if (o_scan_addr == LAST_ADDR) begin
                    applying    <= 1'b1;
                    o_scan_addr <= '0;
                end else begin
                    o_scan_addr <= o_scan_addr + 1'b1;
                end
            end else begin
                o_v_x    <= next_v_x;
                o_v_y    <= next_v_y;
                pos_x    <= pos_x + next_v_x;
                pos_y    <= pos_y + next_v_y;
                applying <= 1'b0;
                o_busy   <= 1'b0;
                o_done   <= 1'b1;
            end
        end
    end

    assert property (@(posedge i_clk) disable iff (i_reset) o_done |=> !o_done);

    // scan plus one apply cycle, then idle
    assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_busy) |-> o_busy [*NUM_SEGMENTS + 1] ##1 !o_busy);

endmodule

//--- verilog/race_collision_top.sv
`timescale 1ns/1ps

module race_collision_top #(
    parameter int NUM_SEGMENTS   = 8,
    parameter int SEG_ADDR_WIDTH = $clog2(NUM_SEGMENTS)
) (
    input  logic                                         i_clk,
    input  logic                                         i_reset,
    input  logic                                         i_seg_we,
    input  logic [SEG_ADDR_WIDTH-1:0]                    i_seg_addr,
    input  map_pkg::segment_t                            i_seg_data,
    input  logic                                         i_load,
    input  logic signed [map_pkg::MAP_H_WIDTH-1:0]       i_x0,
    input  logic signed [map_pkg::MAP_V_WIDTH-1:0]       i_y0,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_vx0,
    input  logic signed [motion_pkg::VELOCITY_WIDTH-1:0] i_vy0,
    input  logic                                         i_step,
    output logic signed [map_pkg::MAP_H_WIDTH-1:0]       o_x,
    output logic signed [map_pkg::MAP_V_WIDTH-1:0]       o_y,
    output logic signed [motion_pkg::VELOCITY_WIDTH-1:0] o_v_x,
    output logic signed [motion_pkg::VELOCITY_WIDTH-1:0] o_v_y,
    output logic                                         o_busy,
    output logic                                         o_done,
    output logic                                         o_hit_x,
    output logic                                         o_hit_y
);
    import map_pkg::*;

    logic [SEG_ADDR_WIDTH-1:0] scan_addr;
    segment_t                  scan_seg;
    logic                      flip_x;
    logic                      flip_y;

    track_table #(
        .NUM_SEGMENTS   (NUM_SEGMENTS),
        .SEG_ADDR_WIDTH (SEG_ADDR_WIDTH)
    ) u_track_table (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_seg_we   (i_seg_we),
        .i_seg_addr (i_seg_addr),
        .i_seg_data (i_seg_data),
        .i_busy     (o_busy),
        .i_rd_addr  (scan_addr),
        .o_rd_seg   (scan_seg)
    );

    segment_collision u_segment_collision (
        .i_seg    (scan_seg),
        .i_x      (o_x),
        .i_y      (o_y),
        .i_v_x    (o_v_x),
        .i_v_y    (o_v_y),
        .o_flip_x (flip_x),
        .o_flip_y (flip_y)
    );

    car_motion #(
        .NUM_SEGMENTS   (NUM_SEGMENTS),
        .SEG_ADDR_WIDTH (SEG_ADDR_WIDTH)
    ) u_car_motion (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_load      (i_load),
        .i_x0        (i_x0),
        .i_y0        (i_y0),
        .i_vx0       (i_vx0),
        .i_vy0       (i_vy0),
        .i_step      (i_step),
        .i_flip_x    (flip_x),
        .i_flip_y    (flip_y),
        .o_scan_addr (scan_addr),
        .o_x         (o_x),
        .o_y         (o_y),
        .o_v_x       (o_v_x),
        .o_v_y       (o_v_y),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_hit_x     (o_hit_x),
        .o_hit_y     (o_hit_y)
    );

endmodule

//--- verilog/track_table.sv
`timescale 1ns/1ps

module track_table #(
    parameter int NUM_SEGMENTS   = 8,
    parameter int SEG_ADDR_WIDTH = $clog2(NUM_SEGMENTS)
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_seg_we,
    input  logic [SEG_ADDR_WIDTH-1:0] i_seg_addr,
    input  map_pkg::segment_t         i_seg_data,
    input  logic                      i_busy,
    input  logic [SEG_ADDR_WIDTH-1:0] i_rd_addr,
    output map_pkg::segment_t         o_rd_seg
);
    import map_pkg::*;

    segment_t seg_mem [NUM_SEGMENTS];
    logic     wr_en;

    // map is frozen while a step scans it
    assign wr_en = i_seg_we && !i_busy && (i_seg_addr < NUM_SEGMENTS);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_SEGMENTS; i++) begin
                seg_mem[i].kind <= SEG_NONE;
            end
        end else if (wr_en) begin
            seg_mem[i_seg_addr] <= i_seg_data;
        end
    end

    // scanner sees the word in the same cycle
    assign o_rd_seg = seg_mem[i_rd_addr];

    // writes only land while the scanner is parked on word 0
    assert property (@(posedge i_clk) disable iff (i_reset)
        wr_en |-> i_rd_addr == '0);

endmodule
